/* build.f */
+incdir+src
src/rvv_pkg.sv
src/rvv_ifs.sv
src/rvv_cmd_fifo.sv
src/rvv_decode.sv
src/rvv_alu.sv
src/rvv_vrf.sv
src/rvv_backend.sv
verif/tb_clk_gen.sv
verif/tb_rvv_backend.sv

/* Bender.yml */
package:
  name: rvv_backend

export_include_dirs:
  - src

sources:
  - src/rvv_pkg.sv
  - src/rvv_ifs.sv
  - src/rvv_cmd_fifo.sv
  - src/rvv_decode.sv
  - src/rvv_alu.sv
  - src/rvv_vrf.sv
  - src/rvv_backend.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_rvv_backend.sv

/* verif/tb_rvv_backend.sv */
`timescale 1ns/1ps
`include "rvv_config.svh"

module tb_rvv_backend;
    import rvv_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic                        clk;
    logic                        rst_n;
    logic      [`ISSUE_LANE-1:0] insts_valid;
    rvv_cmd_t  [`ISSUE_LANE-1:0] insts;
    logic      [`ISSUE_LANE-1:0] insts_ready;
    logic      [`NUM_EX-1:0]     rt_valid;
    logic      [`NUM_EX-1:0]     rt_illegal;
    vreg_idx_t [`NUM_EX-1:0]     rt_vd;
    vreg_t     [`NUM_EX-1:0]     rt_data;

    vreg_t    vrf_model [`NUM_VREG];
    rvv_cmd_t exp_q [$];
    rvv_cmd_t lane_word [`ISSUE_LANE];
    int       accepted_total;
    int       retired_total;
    logic     run_checks;
    string    cur_test;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    rvv_backend i_rvv_backend (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts       (insts),
        .insts_ready (insts_ready),
        .rt_valid    (rt_valid),
        .rt_illegal  (rt_illegal),
        .rt_vd       (rt_vd),
        .rt_data     (rt_data)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_value(input string what, input logic [`VLEN-1:0] expected,
                               input logic [`VLEN-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[FAIL] %s %s expected %0h actual %0h",
                                cur_test, what, expected, actual));
        end
    endtask

    function automatic logic known_f6(input logic [5:0] f6);
        return f6 inside {6'b000000, 6'b000010, 6'b001001, 6'b001010, 6'b001011};
    endfunction

    function automatic logic is_legal(input rvv_cmd_t c);
        return c[6:0] == 7'b1010111 && c[14:12] == 3'b000 && known_f6(c[31:26]);
    endfunction

    // Elementwise vs2 op vs1 on the model registers
    function automatic vreg_t ref_result(input rvv_cmd_t c);
        vreg_t           res;
        logic [`SEW-1:0] a;
        logic [`SEW-1:0] b;
        res = '0;
        for (int e = 0; e < `VLEN / `SEW; e++) begin
            a = vrf_model[c[24:20]][e*`SEW +: `SEW];
            b = vrf_model[c[19:15]][e*`SEW +: `SEW];
            case (c[31:26])
                6'b000000: res[e*`SEW +: `SEW] = a + b;
                6'b000010: res[e*`SEW +: `SEW] = a - b;
                6'b001001: res[e*`SEW +: `SEW] = a & b;
                6'b001010: res[e*`SEW +: `SEW] = a | b;
                default:   res[e*`SEW +: `SEW] = a ^ b;
            endcase
        end
        return res;
    endfunction

    function automatic rvv_cmd_t make_legal(input int op, input vreg_idx_t vd,
                                            input vreg_idx_t vs2, input vreg_idx_t vs1);
        logic [5:0] f6;
        case (op)
            0:       f6 = 6'b000000;
            1:       f6 = 6'b000010;
            2:       f6 = 6'b001001;
            3:       f6 = 6'b001010;
            default: f6 = 6'b001011;
        endcase
        return {f6, 1'b1, vs2, vs1, 3'b000, vd, 7'b1010111};
    endfunction

    function automatic rvv_cmd_t rand_legal();
        return make_legal($urandom % 5, 5'($urandom), 5'($urandom), 5'($urandom));
    endfunction

    // Corrupts one of funct6, funct3 or opcode
    function automatic rvv_cmd_t make_illegal();
        rvv_cmd_t   c;
        logic [5:0] f6;
        c = rand_legal();
        f6 = 6'($urandom);
        case ($urandom % 3)
            0:       c[31:26] = known_f6(f6) ? f6 ^ 6'b100000 : f6;
            1:       c[14:12] = 3'($urandom % 7 + 1);
            default: c[6:0] = c[6:0] ^ 7'($urandom % 127 + 1);
        endcase
        return c;
    endfunction

    task automatic retire_lane(input int l);
        rvv_cmd_t c;
        logic     legal;
        vreg_t    expected;
        if (exp_q.size() == 0) begin
            abort_run("a lane retired while no accepted instruction was outstanding");
        end else begin
            c = exp_q.pop_front();
            legal = is_legal(c);
            expected = legal ? ref_result(c) : '0;
            check_value($sformatf("lane%0d vd", l), c[11:7], rt_vd[l]);
            check_value($sformatf("lane%0d illegal", l), !legal, rt_illegal[l]);
            check_value($sformatf("lane%0d data", l), expected, rt_data[l]);
            if (legal) begin
                vrf_model[c[11:7]] = expected;
            end
            retired_total++;
        end
    endtask

    // Retire lane0 first, then record this edge's accepted lanes
    always @(posedge clk) begin
        if (run_checks) begin
            for (int l = 0; l < `NUM_EX; l++) begin
                if (rt_valid[l]) begin
                    retire_lane(l);
                end
            end
            for (int k = 0; k < `ISSUE_LANE; k++) begin
                if (insts_valid[k] && insts_ready[k]) begin
                    exp_q.push_back(insts[k]);
                    accepted_total++;
                end
            end
        end
    end

    // Occupancy is what was accepted minus what has been popped
    always @(negedge clk) begin : ready_model
        int                     occ;
        logic [`ISSUE_LANE-1:0] exp_ready;
        if (run_checks) begin
            occ = accepted_total - retired_total - $countones(rt_valid);
            for (int k = 0; k < `ISSUE_LANE; k++) begin
                exp_ready[k] = (`CQ_DEPTH - occ) > k;
            end
            check_value("insts_ready", exp_ready, insts_ready);
        end
    end

    task automatic present(input int n, input bit wait_room);
        int waited;
        waited = 0;
        @(negedge clk);
        if (wait_room) begin
            insts_valid = '0;
            while (!insts_ready[n-1]) begin
                if (waited >= WAIT_LIMIT) begin
                    abort_run("timed out waiting for room in the command queue");
                end else begin
                    waited++;
                    @(negedge clk);
                end
            end
        end
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            insts[k]       = (k < n) ? lane_word[k] : rvv_cmd_t'($urandom);
            insts_valid[k] = (k < n);
        end
    endtask

    task automatic drain_all();
        int waited;
        waited = 0;
        @(negedge clk);
        insts_valid = '0;
        while (exp_q.size() != 0) begin
            if (waited >= WAIT_LIMIT) begin
                abort_run("timed out waiting for outstanding instructions to retire");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    initial begin : stimulus
        int seed;
        int n;
        int waited;
        seed = $urandom(32'hafda_a5d6);
        insts_valid = '0;
        insts = '0;
        run_checks = 1'b0;
        accepted_total = 0;
        retired_total = 0;
        waited = 0;
        for (int i = 0; i < `NUM_VREG; i++) begin
            vrf_model[i] = {(`VLEN / `SEW){`SEW'(i)}};
        end
        cur_test = "reset_state";
        while (rst_n !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                abort_run("timed out waiting for reset to be released");
            end else begin
                waited++;
                @(posedge clk);
            end
        end
        @(negedge clk);
        run_checks = 1'b1;
        check_value("rt_valid", '0, rt_valid);
        check_value("insts_ready", {`ISSUE_LANE{1'b1}}, insts_ready);

        // vi = v0 + vi keeps the pattern and shows it on retire
        cur_test = "reg_reset_pattern";
        for (int i = 0; i < `NUM_VREG; i++) begin
            lane_word[0] = make_legal(0, 5'(i), 5'(i), 5'd0);
            present(1, 1'b1);
        end
        drain_all();

        cur_test = "random_legal";
        repeat (150) begin
            n = $urandom % 4 + 1;
            for (int k = 0; k < n; k++) begin
                lane_word[k] = rand_legal();
            end
            present(n, 1'b1);
        end
        drain_all();

        // Empty queue so each pair reaches decode as the head pair
        cur_test = "same_cycle_dep";
        repeat (60) begin
            lane_word[0] = rand_legal();
            lane_word[1] = rand_legal();
            if ($urandom % 2) begin
                lane_word[1][19:15] = lane_word[0][11:7];
            end else begin
                lane_word[1][24:20] = lane_word[0][11:7];
            end
            present(2, 1'b1);
            drain_all();
        end

        cur_test = "illegal_inst";
        repeat (60) begin
            n = $urandom % 4 + 1;
            for (int k = 0; k < n; k++) begin
                lane_word[k] = ($urandom % 2) ? make_illegal() : rand_legal();
            end
            present(n, 1'b1);
        end
        drain_all();

        cur_test = "back_pressure";
        repeat (80) begin
            for (int k = 0; k < `ISSUE_LANE; k++) begin
                lane_word[k] = ($urandom % 8 == 0) ? make_illegal() : rand_legal();
            end
            present(`ISSUE_LANE, 1'b0);
        end
        drain_all();

        $display("*** TEST PASSED ***");
        $finish;
    end
endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over 5 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

/* src/rvv_backend.sv */
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic              [`ISSUE_LANE-1:0]  insts_valid,
    input  rvv_pkg::rvv_cmd_t [`ISSUE_LANE-1:0]  insts,
    output logic              [`ISSUE_LANE-1:0]  insts_ready,
    output logic              [`NUM_EX-1:0]      rt_valid,
    output logic              [`NUM_EX-1:0]      rt_illegal,
    output rvv_pkg::vreg_idx_t [`NUM_EX-1:0]     rt_vd,
    output rvv_pkg::vreg_t    [`NUM_EX-1:0]      rt_data
);

    logic [`ISSUE_LANE-1:0] push;

    cq_if     cq ();
    vrf_rd_if rd ();
    uop_if    uop ();
    wb_if     wb ();

    assign push = insts_valid & insts_ready;

    rvv_cmd_fifo u_cmd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (insts),
        .free_gt   (insts_ready),
        .cq        (cq)
    );

    rvv_decode u_decode (
        .cq  (cq),
        .rd  (rd),
        .uop (uop)
    );

    rvv_alu u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .uop   (uop),
        .wb    (wb)
    );

    rvv_vrf u_vrf (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (rd),
        .wb    (wb)
    );

    // Retire straight from the writeback stage
    assign rt_valid   = wb.valid;
    assign rt_illegal = wb.illegal;
    assign rt_vd      = wb.vd;
    assign rt_data    = wb.data;

endmodule

/* src/rvv_vrf.sv */
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_vrf (
    input logic   clk,
    input logic   rst_n,
    vrf_rd_if.vrf rd,
    wb_if.vrf     wb
);
    import rvv_pkg::*;

    vreg_t              regs [`NUM_VREG];
    logic [`NUM_EX-1:0] wr_en;

    assign wr_en = wb.valid & ~wb.illegal;

    // Later lane overrides, so lane1 wins on the same vd
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_VREG; i++) begin
                regs[i] <= {(`VLEN / `SEW){`SEW'(i)}};
            end
        end else begin
            for (int l = 0; l < `NUM_EX; l++) begin
                if (wr_en[l]) begin
                    regs[wb.vd[l]] <= wb.data[l];
                end
            end
        end
    end

    // Results retiring this cycle are forwarded to the reads
    always_comb begin
        for (int p = 0; p < 2*`NUM_EX; p++) begin
            rd.rs_data[p] = regs[rd.rs_idx[p]];
            for (int l = 0; l < `NUM_EX; l++) begin
                if (wr_en[l] && wb.vd[l] == rd.rs_idx[p]) begin
                    rd.rs_data[p] = wb.data[l];
                end
            end
        end
    end

endmodule

/* src/rvv_alu.sv */
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_alu (
    input logic clk,
    input logic rst_n,
    uop_if.alu  uop,
    wb_if.alu   wb
);
    import rvv_pkg::*;

    localparam int NUM_ELEM = `VLEN / `SEW;

    vreg_t [`NUM_EX-1:0] res;

    // vs2 op vs1 per element, sums and differences wrap
    always_comb begin : lane_ops
        logic [`SEW-1:0] a;
        logic [`SEW-1:0] b;
        res = '0;
        for (int l = 0; l < `NUM_EX; l++) begin
            for (int e = 0; e < NUM_ELEM; e++) begin
                a = uop.src2[l][e*`SEW +: `SEW];
                b = uop.src1[l][e*`SEW +: `SEW];
                case (uop.op[l])
                    OP_ADD:  res[l][e*`SEW +: `SEW] = a + b;
                    OP_SUB:  res[l][e*`SEW +: `SEW] = a - b;
                    OP_AND:  res[l][e*`SEW +: `SEW] = a & b;
                    OP_OR:   res[l][e*`SEW +: `SEW] = a | b;
                    OP_XOR:  res[l][e*`SEW +: `SEW] = a ^ b;
                    default: res[l][e*`SEW +: `SEW] = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid   <= '0;
            wb.illegal <= '0;
        end else begin
            wb.valid <= uop.valid;
            for (int l = 0; l < `NUM_EX; l++) begin
                wb.illegal[l] <= (uop.op[l] == OP_ILLEGAL);
            end
        end
    end

    always_ff @(posedge clk) begin
        wb.vd   <= uop.vd;
        wb.data <= res;
    end

endmodule

/* src/rvv_decode.sv */
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_decode (
    cq_if.dec     cq,
    vrf_rd_if.dec rd,
    uop_if.dec    uop
);
    import rvv_pkg::*;

    rvv_cmd_t  cmd [`NUM_EX];
    alu_op_e   op  [`NUM_EX];
    vreg_idx_t vs1 [`NUM_EX];
    vreg_idx_t vs2 [`NUM_EX];
    vreg_idx_t vd  [`NUM_EX];
    logic      raw_hazard;

    function automatic alu_op_e decode_op(input rvv_cmd_t c);
        alu_op_e res;
        res = OP_ILLEGAL;
        if (c[6:0] == OPC_OPV && c[14:12] == F3_OPIVV) begin
            case (c[31:26])
                F6_VADD: res = OP_ADD;
                F6_VSUB: res = OP_SUB;
                F6_VAND: res = OP_AND;
                F6_VOR:  res = OP_OR;
                F6_VXOR: res = OP_XOR;
                default: res = OP_ILLEGAL;
            endcase
        end
        return res;
    endfunction

    assign cmd[0] = cq.data0;
    assign cmd[1] = cq.data1;

    always_comb begin
        for (int l = 0; l < `NUM_EX; l++) begin
            op[l]  = decode_op(cmd[l]);
            vs1[l] = cmd[l][19:15];
            vs2[l] = cmd[l][24:20];
            vd[l]  = cmd[l][11:7];
        end
    end

    // Lane1 waits a cycle if it reads what a legal lane0 writes
    assign raw_hazard = (op[0] != OP_ILLEGAL) && (vs1[1] == vd[0] || vs2[1] == vd[0]);

    assign cq.pop0 = !cq.empty;
    assign cq.pop1 = !cq.empty && !cq.one_left && !raw_hazard;

    always_comb begin
        for (int l = 0; l < `NUM_EX; l++) begin
            rd.rs_idx[2*l]     = vs1[l];
            rd.rs_idx[2*l + 1] = vs2[l];
            uop.op[l]          = op[l];
            uop.vd[l]          = vd[l];
            uop.src1[l]        = rd.rs_data[2*l];
            uop.src2[l]        = rd.rs_data[2*l + 1];
        end
    end

    assign uop.valid = {cq.pop1, cq.pop0};

endmodule

/* src/rvv_cmd_fifo.sv */
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_cmd_fifo (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic             [`ISSUE_LANE-1:0]  push,
    input  rvv_pkg::rvv_cmd_t [`ISSUE_LANE-1:0] push_data,
    output logic             [`ISSUE_LANE-1:0]  free_gt,
    cq_if.fifo                                  cq
);
    import rvv_pkg::*;

    localparam int PTR_W = $clog2(`CQ_DEPTH);
    localparam int CNT_W = $clog2(`CQ_DEPTH + 1);

    rvv_cmd_t         mem [`CQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] push_cnt;
    logic [CNT_W-1:0] pop_cnt;
    logic [PTR_W-1:0] wr_idx [`ISSUE_LANE];

    // Each pushing lane takes the next slot after the lower lanes
    always_comb begin
        push_cnt = '0;
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            wr_idx[k] = wr_ptr + PTR_W'(push_cnt);
            push_cnt  = push_cnt + CNT_W'(push[k]);
        end
    end

    assign pop_cnt = CNT_W'(cq.pop0) + CNT_W'(cq.pop1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push_cnt);
            rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
            count  <= count + push_cnt - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            if (push[k]) begin
                mem[wr_idx[k]] <= push_data[k];
            end
        end
    end

    // Thermometer ready from the registered count
    assign free_cnt = CNT_W'(`CQ_DEPTH) - count;

    always_comb begin
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            free_gt[k] = free_cnt > CNT_W'(k);
        end
    end

    assign cq.data0    = mem[rd_ptr];
    assign cq.data1    = mem[rd_ptr + PTR_W'(1)];
    assign cq.empty    = (count == '0);
    assign cq.one_left = (count == CNT_W'(1));

endmodule

/* src/rvv_ifs.sv */
`timescale 1ns/1ps
`include "rvv_config.svh"

// Two oldest command queue entries towards decode
interface cq_if;
    import rvv_pkg::*;

    rvv_cmd_t data0;
    rvv_cmd_t data1;
    logic     empty;
    logic     one_left;
    logic     pop0;
    logic     pop1;

    modport fifo (output data0, data1, empty, one_left, input pop0, pop1);
    modport dec  (input data0, data1, empty, one_left, output pop0, pop1);
endinterface

// Lane0 vs1, vs2, then lane1 vs1, vs2
interface vrf_rd_if;
    import rvv_pkg::*;

    vreg_idx_t [2*`NUM_EX-1:0] rs_idx;
    vreg_t     [2*`NUM_EX-1:0] rs_data;

    modport dec (output rs_idx, input rs_data);
    modport vrf (input rs_idx, output rs_data);
endinterface

interface uop_if;
    import rvv_pkg::*;

    logic      [`NUM_EX-1:0] valid;
    alu_op_e   [`NUM_EX-1:0] op;
    vreg_idx_t [`NUM_EX-1:0] vd;
    vreg_t     [`NUM_EX-1:0] src1;
    vreg_t     [`NUM_EX-1:0] src2;

    modport dec (output valid, op, vd, src1, src2);
    modport alu (input valid, op, vd, src1, src2);
endinterface

interface wb_if;
    import rvv_pkg::*;

    logic      [`NUM_EX-1:0] valid;
    vreg_idx_t [`NUM_EX-1:0] vd;
    vreg_t     [`NUM_EX-1:0] data;
    logic      [`NUM_EX-1:0] illegal;

    modport alu (output valid, vd, data, illegal);
    modport vrf (input valid, vd, data, illegal);
endinterface

/* src/rvv_pkg.sv */
`include "rvv_config.svh"

package rvv_pkg;

    typedef logic [`VLEN-1:0]   vreg_t;
    typedef logic [4:0]         vreg_idx_t;
    typedef logic [`INST_W-1:0] rvv_cmd_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ILLEGAL
    } alu_op_e;

    // OPIVV encodings
    localparam logic [6:0] OPC_OPV  = 7'b1010111;
    localparam logic [2:0] F3_OPIVV = 3'b000;

    localparam logic [5:0] F6_VADD = 6'b000000;
    localparam logic [5:0] F6_VSUB = 6'b000010;
    localparam logic [5:0] F6_VAND = 6'b001001;
    localparam logic [5:0] F6_VOR  = 6'b001010;
    localparam logic [5:0] F6_VXOR = 6'b001011;

endpackage

/* src/rvv_config.svh */
`ifndef RVV_CONFIG_SVH
`define RVV_CONFIG_SVH

// Input instruction lanes
`define ISSUE_LANE 4

// Decode, execute and retire width
`define NUM_EX 2

// Command queue entries, a power of two
`define CQ_DEPTH 8

`define VLEN 128
`define SEW 8
`define NUM_VREG 32
`define INST_W 32

`endif
